// ==== files.f ====
hdl/mips_pkg.sv
hdl/control.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/data_mem.sv
hdl/pc_select.sv
hdl/exec_core.sv
tests/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - hdl/mips_pkg.sv
  - hdl/control.sv
  - hdl/alu.sv
  - hdl/reg_file.sv
  - hdl/data_mem.sv
  - hdl/pc_select.sv
  - hdl/exec_core.sv
  - target: test
    files:
      - tests/exec_core_tb.sv

// ==== tests/exec_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_core_tb;

    localparam int MEM_WORDS   = 64;
    localparam int CLK_PERIOD  = 4;
    localparam int N_ALU       = 200;
    localparam int N_MEM       = 150;
    localparam int N_FLOW      = 150;
    localparam int N_STALL     = 100;
    localparam int TOTAL_INSTR = 32 + N_ALU + N_MEM + N_FLOW + 2 * N_STALL;

    logic                clk, rst_n, in_valid, in_ready, out_valid, out_ready, out_wr_en;
    mips_pkg::word_t     in_instr, in_pc, out_pc, out_next_pc, out_wr_data;
    mips_pkg::reg_addr_t out_wr_addr;

    integer seed = 27;
    int     errors, err_mark, pass_tests, fail_tests;
    logic   stall_mode;

    mips_pkg::word_t mreg [32];         // Register mirror
    mips_pkg::word_t mmem [MEM_WORDS];  // Memory mirror
    logic            mem_init [8];

    mips_pkg::word_t     exp_pc_q[$], exp_next_q[$], exp_wdata_q[$];
    mips_pkg::reg_addr_t exp_waddr_q[$];
    logic                exp_wen_q[$];
    mips_pkg::word_t     got_next_q[$], got_data_q[$], ref_next_q[$], ref_data_q[$];
    mips_pkg::word_t     prog_instr_q[$], prog_pc_q[$];

    logic                held, held_wen, e_wen;
    mips_pkg::word_t     held_pc, held_next, held_wdata;
    mips_pkg::reg_addr_t held_waddr, e_waddr;
    mips_pkg::word_t     e_wdata;

    exec_core #(.MEM_WORDS(MEM_WORDS)) exec_core_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .in_instr(in_instr), .in_pc(in_pc), .out_valid(out_valid), .out_ready(out_ready),
        .out_pc(out_pc), .out_next_pc(out_next_pc), .out_wr_en(out_wr_en),
        .out_wr_addr(out_wr_addr), .out_wr_data(out_wr_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input mips_pkg::reg_addr_t got,
                             input mips_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ISA reference step that updates the mirrors and queues the expected record
    task automatic model_exec(input mips_pkg::word_t instr, input mips_pkg::word_t pc);
        mips_pkg::opcode_t   op;
        mips_pkg::funct_t    fn;
        mips_pkg::word_t     a, b, simm, zimm, pc4, next, wdata, addr, word;
        mips_pkg::reg_addr_t waddr;
        logic                wen, taken;
        int                  idx;
        logic [7:0]          byte_v;
        op     = instr[31:26];
        fn     = instr[5:0];
        a      = mreg[instr[25:21]];
        b      = mreg[instr[20:16]];
        simm   = {{16{instr[15]}}, instr[15:0]};
        zimm   = {16'h0000, instr[15:0]};
        pc4    = pc + 32'd4;
        next   = pc4;
        wdata  = '0;
        taken  = 1'b0;
        addr   = a + simm;
        idx    = (addr >> 2) % MEM_WORDS;
        word   = mmem[idx];
        byte_v = word >> (8 * addr[1:0]);
        waddr  = (op == 6'h00) ? instr[15:11] : instr[20:16];
        wen    = (op == 6'h00 && fn != 6'h08) || op == 6'h08 || op == 6'h09 || op == 6'h0c ||
                 op == 6'h0d || op == 6'h0e || op == 6'h0f || op == 6'h03 ||
                 op == 6'h23 || op == 6'h20;
        case (op)
            6'h00: begin
                case (fn)
                    6'h00: wdata = b << instr[10:6];
                    6'h02: wdata = b >> instr[10:6];
                    6'h03: wdata = $signed(b) >>> instr[10:6];
                    6'h20, 6'h21: wdata = a + b;
                    6'h22, 6'h23: wdata = a - b;
                    6'h24: wdata = a & b;
                    6'h25: wdata = a | b;
                    6'h26: wdata = a ^ b;
                    6'h27: wdata = ~(a | b);
                    6'h2a: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b: wdata = (a < b) ? 32'd1 : 32'd0;
                    6'h08: next = a; // jr
                    default: wdata = '0;
                endcase
            end
            6'h08: wdata = a + simm;
            6'h09: wdata = a + zimm;
            6'h0c: wdata = a & zimm;
            6'h0d: wdata = a | zimm;
            6'h0e: wdata = a ^ zimm;
            6'h0f: wdata = {instr[15:0], 16'h0000};
            6'h04: taken = (a == b);
            6'h05: taken = (a != b);
            6'h06: taken = ($signed(a) <= 0);
            6'h07: taken = ($signed(a) > 0);
            6'h01: taken = ($signed(a) >= 0);
            6'h02, 6'h03: next = {pc4[31:28], instr[25:0], 2'b00};
            6'h23: wdata = word;
            6'h20: wdata = {{24{byte_v[7]}}, byte_v};
            6'h2b: mmem[idx] = b;
            6'h28: mmem[idx][8 * addr[1:0] +: 8] = b[7:0];
            default: ;
        endcase
        if (taken) begin
            next = pc4 + (simm << 2);
        end
        if (op == 6'h03) begin
            waddr = 5'd31;
            wdata = pc + 32'd8;
        end
        if (wen && waddr != 5'd0) begin
            mreg[waddr] = wdata;
        end
        exp_pc_q.push_back(pc);
        exp_next_q.push_back(next);
        exp_wen_q.push_back(wen);
        exp_waddr_q.push_back(waddr);
        exp_wdata_q.push_back(wdata);
    endtask

    function automatic mips_pkg::word_t gen_alu();
        mips_pkg::funct_t    fn_list [13] = '{6'h00, 6'h02, 6'h03, 6'h20, 6'h21, 6'h22,
                                              6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
        mips_pkg::opcode_t   op_list [6] = '{6'h08, 6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
        mips_pkg::reg_addr_t rs, rt, rd;
        mips_pkg::shamt_t    sh;
        mips_pkg::funct_t    fn;
        mips_pkg::opcode_t   op;
        mips_pkg::word_t     r;
        rs = rand_below(8);
        rt = rand_below(8);
        rd = rand_below(8);
        sh = rand_below(32);
        fn = fn_list[rand_below(13)];
        op = op_list[rand_below(6)];
        r  = $random(seed);
        if (rand_below(2) == 0) begin
            return {6'h00, rs, rt, rd, sh, fn};
        end
        return {op, rs, rt, r[15:0]};
    endfunction

    function automatic mips_pkg::word_t gen_mem();
        mips_pkg::opcode_t   op_list [4] = '{6'h2b, 6'h28, 6'h23, 6'h20};
        mips_pkg::opcode_t   op;
        mips_pkg::reg_addr_t rt;
        logic [2:0]          w;
        logic [1:0]          lane;
        op   = op_list[rand_below(4)];
        rt   = rand_below(8);
        w    = rand_below(8);
        lane = rand_below(4);
        if (!mem_init[w]) begin
            op = 6'h2b; // First touch of a word is a full store
        end
        if (op == 6'h2b || op == 6'h23) begin
            lane = 2'd0;
        end
        if (op == 6'h2b) begin
            mem_init[w] = 1'b1;
        end
        return {op, 5'd0, rt, 11'd0, w, lane};
    endfunction

    function automatic mips_pkg::word_t gen_flow();
        mips_pkg::opcode_t   op_list [10] = '{6'h04, 6'h05, 6'h06, 6'h07, 6'h01,
                                              6'h02, 6'h03, 6'h00, 6'h14, 6'h3f};
        mips_pkg::opcode_t   op;
        mips_pkg::reg_addr_t rs, rt;
        mips_pkg::word_t     r;
        op = op_list[rand_below(10)];
        rs = rand_below(8);
        rt = rand_below(8);
        r  = $random(seed);
        if (op == 6'h02 || op == 6'h03) begin
            return {op, r[25:0]};
        end
        if (op == 6'h00) begin
            return {6'h00, rs, 15'd0, 6'h08}; // jr
        end
        if (op == 6'h01) begin
            rt = 5'd1;
        end
        if (op == 6'h04 && rand_below(4) == 0) begin
            rt = rs;
        end
        return {op, rs, rt, r[15:0]};
    endfunction

    function automatic mips_pkg::word_t rand_pc();
        mips_pkg::word_t r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    task automatic apply_reset();
        rst_n    = 1'b0;
        in_valid = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < 32; i++) begin
            mreg[i] = '0;
        end
    endtask

    task automatic issue(input mips_pkg::word_t instr, input mips_pkg::word_t pc);
        in_valid = 1'b1;
        in_instr = instr;
        in_pc    = pc;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk); // Accepting edge
        model_exec(instr, pc);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_pc_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
        check_bit("out_valid", out_valid, 1'b0); // No record left over
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            pass_tests++;
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    always @(posedge clk) begin
        #1;
        out_ready = stall_mode ? (rand_below(2) == 1) : 1'b1;
    end

    // Retire monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            held = 1'b0;
        end else begin
            if (held && (out_valid !== 1'b1 || out_pc !== held_pc || out_next_pc !== held_next ||
                         out_wr_en !== held_wen || out_wr_addr !== held_waddr ||
                         out_wr_data !== held_wdata)) begin
                $display("retire record for pc %h changed while stalled", held_pc);
                errors++;
            end
            if (out_valid && out_ready) begin
                if (exp_pc_q.size() == 0) begin
                    $display("retire record at pc %h without an accepted instruction", out_pc);
                    errors++;
                end else begin
                    check_word("out_pc", out_pc, exp_pc_q.pop_front());
                    check_word("out_next_pc", out_next_pc, exp_next_q.pop_front());
                    e_wen   = exp_wen_q.pop_front();
                    e_waddr = exp_waddr_q.pop_front();
                    e_wdata = exp_wdata_q.pop_front();
                    check_bit("out_wr_en", out_wr_en, e_wen);
                    if (e_wen) begin
                        check_reg("out_wr_addr", out_wr_addr, e_waddr);
                        check_word("out_wr_data", out_wr_data, e_wdata);
                    end
                    got_next_q.push_back(out_next_pc);
                    got_data_q.push_back(out_wr_en ? out_wr_data : '0);
                end
            end
            held       = out_valid && !out_ready;
            held_pc    = out_pc;
            held_next  = out_next_pc;
            held_wen   = out_wr_en;
            held_waddr = out_wr_addr;
            held_wdata = out_wr_data;
        end
    end

    initial begin
        #(CLK_PERIOD * 20 * TOTAL_INSTR);
        $display("timeout: retire records stopped arriving");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        mips_pkg::reg_addr_t r;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        in_pc      = '0;
        out_ready  = 1'b1;
        stall_mode = 1'b0;
        held       = 1'b0;
        for (int i = 0; i < 8; i++) begin
            mem_init[i] = 1'b0;
        end
        apply_reset();

        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        @(posedge clk);
        #1;
        for (int k = 0; k < 32; k++) begin
            r = k;
            issue({6'h00, 5'd0, r, r, 5'd0, 6'h21}, rand_pc()); // addu rk, r0, rk
        end
        drain();
        end_test("reset_and_zero_regs");

        for (int k = 0; k < N_ALU; k++) begin
            issue(gen_alu(), rand_pc());
        end
        drain();
        end_test("alu_random");

        for (int k = 0; k < N_MEM; k++) begin
            issue(gen_mem(), rand_pc());
        end
        drain();
        end_test("memory_random");

        for (int k = 0; k < N_FLOW; k++) begin
            issue((rand_below(2) == 0) ? gen_alu() : gen_flow(), rand_pc());
        end
        drain();
        end_test("branch_jump");

        for (int k = 0; k < N_STALL; k++) begin
            prog_instr_q.push_back((rand_below(2) == 0) ? gen_alu() : gen_flow());
            prog_pc_q.push_back(rand_pc());
        end
        apply_reset();
        got_next_q.delete();
        got_data_q.delete();
        foreach (prog_instr_q[i]) issue(prog_instr_q[i], prog_pc_q[i]);
        drain();
        ref_next_q = got_next_q;
        ref_data_q = got_data_q;
        apply_reset();
        got_next_q.delete();
        got_data_q.delete();
        stall_mode = 1'b1; // Random back-pressure
        foreach (prog_instr_q[i]) issue(prog_instr_q[i], prog_pc_q[i]);
        drain();
        stall_mode = 1'b0;
        foreach (ref_next_q[i]) begin
            check_word("out_next_pc", got_next_q[i], ref_next_q[i]);
            check_word("out_wr_data", got_data_q[i], ref_data_q[i]);
        end
        end_test("backpressure");

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_tests, fail_tests, errors);
        if (fail_tests == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_core #(
    parameter int MEM_WORDS = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  mips_pkg::word_t     in_instr,
    input  mips_pkg::word_t     in_pc,
    output logic                out_valid,
    input  logic                out_ready,
    output mips_pkg::word_t     out_pc,
    output mips_pkg::word_t     out_next_pc,
    output logic                out_wr_en,
    output mips_pkg::reg_addr_t out_wr_addr,
    output mips_pkg::word_t     out_wr_data
);

    logic                accept;
    mips_pkg::reg_addr_t rs, rt, rd;
    mips_pkg::shamt_t    shamt;
    logic                reg_dst, mem_to_reg, reg_write, mem_write;
    logic                jr, do_extend, is_byte, zero;
    logic [1:0]          alu_src;
    mips_pkg::branch_t   branch;
    mips_pkg::alu_op_t   alu_op;
    mips_pkg::jump_t     jump;
    mips_pkg::word_t     rs_data, rt_data, imm_sext, imm_zext, imm_ext;
    mips_pkg::word_t     alu_a, alu_b, alu_result, mem_data, next_pc;
    mips_pkg::reg_addr_t wr_addr;
    mips_pkg::word_t     wr_data;

    assign in_ready = ~out_valid | out_ready;
    assign accept   = in_valid & in_ready;

    assign rs    = in_instr[25:21];
    assign rt    = in_instr[20:16];
    assign rd    = in_instr[15:11];
    assign shamt = in_instr[10:6];

    control control_i (
        .opcode(in_instr[31:26]), .func(in_instr[5:0]), .reg_dst(reg_dst),
        .alu_src(alu_src), .mem_to_reg(mem_to_reg), .reg_write(reg_write),
        .mem_read(), .mem_write(mem_write), .branch(branch), .alu_op(alu_op),
        .jr(jr), .jump(jump), .do_extend(do_extend), .is_byte(is_byte)
    );

    reg_file reg_file_i (
        .clk(clk), .rst_n(rst_n), .rd_addr_a(rs), .rd_addr_b(rt),
        .wr_en(accept & reg_write), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_data_a(rs_data), .rd_data_b(rt_data)
    );

    assign imm_sext = {{16{in_instr[15]}}, in_instr[15:0]};
    assign imm_zext = {16'h0000, in_instr[15:0]};
    assign imm_ext  = do_extend ? imm_sext : imm_zext;

    assign alu_a = alu_src[0] ? {27'b0, shamt} : rs_data;
    assign alu_b = alu_src[1] ? imm_ext : rt_data;

    alu alu_i (
        .alu_op(alu_op), .func(in_instr[5:0]), .a(alu_a), .b(alu_b),
        .result(alu_result), .zero(zero)
    );

    data_mem #(.MEM_WORDS(MEM_WORDS)) data_mem_i (
        .clk(clk), .wr_en(accept & mem_write), .is_byte(is_byte),
        .addr(alu_result), .wr_data(rt_data), .rd_data(mem_data)
    );

    pc_select pc_select_i (
        .pc(in_pc), .instr_index(in_instr[25:0]), .imm(imm_sext), .rs_value(rs_data),
        .zero(zero), .branch(branch), .jump(jump), .jr(jr), .next_pc(next_pc)
    );

    // Destination and write-back value
    assign wr_addr = (jump == mips_pkg::JMP_JAL) ? mips_pkg::LINK_REG : (reg_dst ? rd : rt);
    assign wr_data = mem_to_reg ? mem_data :
                     (jump == mips_pkg::JMP_JAL) ? in_pc + 32'd8 : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0; // Record taken, nothing new
        end
    end

    // Retire payload, held while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc      <= in_pc;
            out_next_pc <= next_pc;
            out_wr_en   <= reg_write;
            out_wr_addr <= wr_addr;
            out_wr_data <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pc_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_select (
    input  mips_pkg::word_t   pc,
    input  logic [25:0]       instr_index,
    input  mips_pkg::word_t   imm,
    input  mips_pkg::word_t   rs_value,
    input  logic              zero,
    input  mips_pkg::branch_t branch,
    input  mips_pkg::jump_t   jump,
    input  logic              jr,
    output mips_pkg::word_t   next_pc
);

    mips_pkg::word_t pc_plus4;
    logic            rs_neg;
    logic            rs_zero;
    logic            taken;

    assign pc_plus4 = pc + 32'd4;
    assign rs_neg   = rs_value[31];
    assign rs_zero  = (rs_value == '0);

    always_comb begin
        case (branch)
            mips_pkg::BR_EQ:  taken = zero;
            mips_pkg::BR_NE:  taken = ~zero;
            mips_pkg::BR_LEZ: taken = rs_neg | rs_zero;
            mips_pkg::BR_GTZ: taken = ~rs_neg & ~rs_zero;
            mips_pkg::BR_GEZ: taken = ~rs_neg;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        if (jr) begin
            next_pc = rs_value;
        end else if (jump == mips_pkg::JMP_J || jump == mips_pkg::JMP_JAL) begin
            next_pc = {pc_plus4[31:28], instr_index, 2'b00}; // Region jump
        end else if (taken) begin
            next_pc = pc_plus4 + {imm[29:0], 2'b00};
        end else begin
            next_pc = pc_plus4;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
    parameter int MEM_WORDS = 64
) (
    input  logic            clk,
    input  logic            wr_en,
    input  logic            is_byte,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t wr_data,
    output mips_pkg::word_t rd_data
);

    mips_pkg::word_t mem [MEM_WORDS];

    mips_pkg::word_t word_idx;
    logic [1:0]      lane;
    mips_pkg::word_t rd_word;
    logic [7:0]      rd_byte;

    assign word_idx = {2'b00, addr[31:2]} % MEM_WORDS; // Wraps around
    assign lane     = addr[1:0];

    assign rd_word = mem[word_idx];
    assign rd_byte = rd_word[lane*8 +: 8]; // Little endian
    assign rd_data = is_byte ? {{24{rd_byte[7]}}, rd_byte} : rd_word;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (is_byte) begin
                mem[word_idx][lane*8 +: 8] <= wr_data[7:0];
            end else begin
                mem[word_idx] <= wr_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t rd_addr_a,
    input  mips_pkg::reg_addr_t rd_addr_b,
    input  logic                wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     rd_data_a,
    output mips_pkg::word_t     rd_data_b
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin // r0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::funct_t  func,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    output mips_pkg::word_t   result,
    output logic              zero
);

    logic [4:0] sh; // Shift distance

    assign sh = a[4:0];

    always_comb begin
        result = '0;
        case (alu_op)
            mips_pkg::ALU_RTYPE: begin
                case (func)
                    6'h00: result = b << sh;                   // sll
                    6'h02: result = b >> sh;                   // srl
                    6'h03: result = $signed(b) >>> sh;         // sra
                    6'h20, 6'h21: result = a + b;              // add, addu
                    6'h22, 6'h23: result = a - b;              // sub, subu
                    6'h24: result = a & b;
                    6'h25: result = a | b;
                    6'h26: result = a ^ b;
                    6'h27: result = ~(a | b);
                    6'h2a: result = {31'b0, $signed(a) < $signed(b)};
                    6'h2b: result = {31'b0, a < b};
                    default: result = '0;
                endcase
            end
            mips_pkg::ALU_ADD,
            mips_pkg::ALU_ADDU:   result = a + b; // No overflow trap
            mips_pkg::ALU_AND:    result = a & b;
            mips_pkg::ALU_XOR:    result = a ^ b;
            mips_pkg::ALU_OR:     result = a | b;
            mips_pkg::ALU_LUI:    result = {b[15:0], 16'h0000};
            mips_pkg::ALU_SUB_BR: result = a - b;
            default:              result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== hdl/control.sv ====
`timescale 1ns/100ps
`default_nettype none

module control (
    input  mips_pkg::opcode_t opcode,
    input  mips_pkg::funct_t  func,
    output logic              reg_dst,
    output logic [1:0]        alu_src, // [0] shamt for a, [1] imm for b
    output logic              mem_to_reg,
    output logic              reg_write,
    output logic              mem_read,
    output logic              mem_write,
    output mips_pkg::branch_t branch,
    output mips_pkg::alu_op_t alu_op,
    output logic              jr,
    output mips_pkg::jump_t   jump,
    output logic              do_extend,
    output logic              is_byte
);

    always_comb begin
        reg_dst    = 1'b0;
        alu_src    = 2'b00;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = mips_pkg::BR_NONE;
        alu_op     = mips_pkg::ALU_RTYPE;
        jr         = 1'b0;
        jump       = mips_pkg::JMP_NONE;
        do_extend  = 1'b1;
        is_byte    = 1'b0;
        casez (opcode)
            6'b000000: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                case (func)
                    6'h00, 6'h02, 6'h03: alu_src[0] = 1'b1; // sll, srl, sra
                    6'h08: begin
                        jr        = 1'b1;
                        reg_write = 1'b0;
                    end
                    default: ;
                endcase
            end
            6'b001000: begin // addi
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = mips_pkg::ALU_ADD;
            end
            6'b001001: begin // addiu
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = mips_pkg::ALU_ADDU;
                do_extend = 1'b0;
            end
            6'b001100: begin // andi
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = mips_pkg::ALU_AND;
                do_extend = 1'b0;
            end
            6'b001101: begin // ori
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = mips_pkg::ALU_OR;
                do_extend = 1'b0;
            end
            6'b001110: begin // xori
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = mips_pkg::ALU_XOR;
                do_extend = 1'b0;
            end
            6'b001111: begin // lui
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = mips_pkg::ALU_LUI;
            end
            6'b0001??: begin // beq, bne, blez, bgtz
                branch = opcode[2:0];
                alu_op = mips_pkg::ALU_SUB_BR;
            end
            6'b000001: branch = mips_pkg::BR_GEZ; // Only bgez in this subset
            6'b000010: jump = mips_pkg::JMP_J;
            6'b000011: begin // jal
                jump      = mips_pkg::JMP_JAL;
                reg_write = 1'b1;
            end
            6'b100011, 6'b100000: begin // lw, lb
                alu_src    = 2'b10;
                reg_write  = 1'b1;
                alu_op     = mips_pkg::ALU_ADD;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                is_byte    = ~opcode[1];
            end
            6'b101011, 6'b101000: begin // sw, sb
                alu_src   = 2'b10;
                alu_op    = mips_pkg::ALU_ADD;
                mem_write = 1'b1;
                is_byte   = ~opcode[1];
            end
            default: ; // Unknown, no side effects
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  branch_t;
    typedef logic [1:0]  jump_t;

    // ALU operations, RTYPE hands the choice to the function field
    localparam alu_op_t ALU_RTYPE  = 4'd0;
    localparam alu_op_t ALU_ADD    = 4'd1;
    localparam alu_op_t ALU_ADDU   = 4'd2;
    localparam alu_op_t ALU_AND    = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_OR     = 4'd5;
    localparam alu_op_t ALU_LUI    = 4'd7;
    localparam alu_op_t ALU_SUB_BR = 4'd8;

    // Branch kinds match the low opcode bits of 4..7
    localparam branch_t BR_NONE = 3'd0;
    localparam branch_t BR_GEZ  = 3'd1;
    localparam branch_t BR_EQ   = 3'd4;
    localparam branch_t BR_NE   = 3'd5;
    localparam branch_t BR_LEZ  = 3'd6;
    localparam branch_t BR_GTZ  = 3'd7;

    localparam jump_t JMP_NONE = 2'd0;
    localparam jump_t JMP_J    = 2'd1;
    localparam jump_t JMP_JAL  = 2'd2;

    localparam reg_addr_t LINK_REG = 5'd31; // jal destination

endpackage

`default_nettype wire
